// File: filelist.f
src/radio_pkg.sv
src/radio_ctrl_proc.sv
src/timekeeper.sv
src/radio_settings.sv
src/fe_atr.sv
src/radio_ctrl_top.sv
verif/tb_clkgen.sv
verif/radio_ctrl_asserts.sv
verif/radio_ctrl_tb.sv

// File: verif/radio_ctrl_tb.sv
/*
 * Testbench for the radio control core. Responses are checked beat by beat
 * against a register model; time readbacks only against a window.
 * i_rx is held constant for the whole run.
 */
`timescale 1ns/100ps

module radio_ctrl_tb;

   localparam int          CLK_PERIOD     = 20;
   localparam int          TIMEOUT_CYCLES = 4000;   // ~60 commands x 30 cycles, plus margin
   localparam logic [31:0] SID            = 32'hC0DE_0042;

   typedef struct packed {
      logic [63:0] hdr;
      logic [63:0] lo;   // Data window, lo == hi when exact
      logic [63:0] hi;
   } exp_t;

   logic               radio_clk;
   logic               i_arst_n;
   radio_pkg::stream_t i_ctrl;
   logic               i_ctrl_tvalid;
   logic               o_ctrl_tready;
   radio_pkg::stream_t o_resp;
   logic               o_resp_tvalid;
   logic               i_resp_tready;
   logic               i_pps;
   logic [31:0]        i_rx;
   logic [31:0]        o_fe_atr;

   // Register model
   logic [31:0]        test_m;
   logic [1:0]         run_m;
   radio_pkg::rb_sel_e rb_sel_m;
   logic [31:0]        atr_m [4];

   exp_t        exp_q [$];
   exp_t        cur_exp;
   logic        in_data;
   logic        bp_en;
   logic [11:0] seq;
   logic [63:0] win_lo;
   logic [63:0] win_hi;
   logic [63:0] last_rb;
   logic [63:0] t_load;
   logic [63:0] pps_val;
   int          cycles = 0;

   tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) clkgen (.o_clk(radio_clk));

   radio_ctrl_top i_dut (.*);

   bind radio_ctrl_proc radio_ctrl_asserts proc_asserts (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_ctrl        (i_ctrl),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .i_ctrl_tready (o_ctrl_tready),
      .i_resp        (o_resp),
      .i_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .i_set         (o_set)
   );

   task automatic step(input int n);
      repeat (n) begin
         @(posedge radio_clk);
         #2;
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] lo, input logic [63:0] hi);
      if (got < lo || got > hi) begin
         if (lo == hi) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, lo);
         end else begin
            $display("CHECK FAILED %s got %h expected %h..%h", name, got, lo, hi);
         end
         $display("SOME TESTS FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // Holds the beat until the DUT takes it; ready depends only on DUT state
   task automatic send_beat(input logic [63:0] data, input logic last);
      i_ctrl_tvalid = 1'b1;
      i_ctrl        = '{tlast: last, tdata: data};
      while (!o_ctrl_tready) begin
         step(1);
      end
      step(1);
      i_ctrl_tvalid = 1'b0;
   endtask

   task automatic apply_write(input radio_pkg::set_word_t sw);
      case (sw.addr)
         radio_pkg::SR_TEST:     test_m = sw.data;
         radio_pkg::SR_RUN:      run_m = sw.data[1:0];
         radio_pkg::SR_READBACK: rb_sel_m = radio_pkg::rb_sel_e'(sw.data[1:0]);
         default: begin
            if (sw.addr >= radio_pkg::SR_ATR && sw.addr < radio_pkg::SR_ATR + 8'd4) begin
               atr_m[2'(sw.addr - radio_pkg::SR_ATR)] = sw.data;
            end
         end
      endcase
   endtask

   // fe_prev is the front-end output before this write, as it lags a cycle
   function automatic exp_t ref_resp(input radio_pkg::ctrl_hdr_t hdr, input logic err,
                                     input logic [31:0] fe_prev);
      radio_pkg::ctrl_hdr_t rh;
      exp_t                 e;
      rh          = hdr;
      rh.pkt_type = err ? radio_pkg::PKT_ERR : radio_pkg::PKT_RESP;
      rh.reserved = '0;
      e.hdr       = rh;
      if (err) begin
         e.lo = '0;
      end else if (rb_sel_m == radio_pkg::RB_TEST) begin
         e.lo = {32'd0, test_m};
      end else if (rb_sel_m == radio_pkg::RB_IO) begin
         e.lo = {fe_prev, i_rx};
      end else begin
         e.lo = win_lo;   // Time sources move every cycle
      end
      e.hi = (!err && rb_sel_m inside {radio_pkg::RB_TIME, radio_pkg::RB_LASTPPS}) ?
             win_hi : e.lo;
      return e;
   endfunction

   task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data);
      radio_pkg::ctrl_hdr_t hdr;
      radio_pkg::set_word_t sw;
      logic [31:0]          fe_prev;
      hdr     = '{pkt_type: radio_pkg::PKT_CMD, seqnum: seq, sid: SID, reserved: '0};
      sw      = '{reserved: '0, addr: addr, data: data};
      fe_prev = atr_m[run_m];
      apply_write(sw);
      exp_q.push_back(ref_resp(hdr, 1'b0, fe_prev));
      seq++;
      send_beat(hdr, 1'b0);
      send_beat(sw, 1'b1);
   endtask

   // One beat ends on the header, three beats overrun the payload
   task automatic send_bad(input int beats);
      radio_pkg::ctrl_hdr_t hdr;
      hdr = '{pkt_type: radio_pkg::PKT_CMD, seqnum: seq, sid: SID, reserved: '0};
      exp_q.push_back(ref_resp(hdr, 1'b1, 32'd0));
      seq++;
      send_beat(hdr, beats == 1);
      if (beats > 1) begin
         send_beat({24'd0, radio_pkg::SR_TEST, 32'hDEAD_BEEF}, 1'b0);
         send_beat(64'd0, 1'b1);
      end
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0) begin
         step(1);
      end
   endtask

   always @(posedge radio_clk) begin
      #2;
      i_resp_tready = bp_en ? ($urandom % 3 != 0) : 1'b1;
   end

   always @(posedge radio_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   // Bound protocol assertions count their failures
   always @(posedge radio_clk) begin
      if (i_dut.radio_ctrl_proc.proc_asserts.fail_cnt != 0) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Protocol assertion failed in the command processor");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response checker, samples mid-cycle once tready is settled
   always begin
      @(posedge radio_clk);
      #5;
      if (o_resp_tvalid && i_resp_tready && exp_q.size() == 0) begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Response beat arrived with no command outstanding");
      end else if (o_resp_tvalid && i_resp_tready) begin
         cur_exp = exp_q[0];
         if (!in_data) begin
            check_value("o_resp.tlast", o_resp.tlast, 64'd0, 64'd0);
            check_value("o_resp.tdata header", o_resp.tdata, cur_exp.hdr, cur_exp.hdr);
            in_data = 1'b1;
         end else begin
            check_value("o_resp.tlast", o_resp.tlast, 64'd1, 64'd1);
            check_value("o_resp.tdata readback", o_resp.tdata, cur_exp.lo, cur_exp.hi);
            last_rb = o_resp.tdata;
            void'(exp_q.pop_front());
            in_data = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      void'($urandom(30));
      i_arst_n      = 1'b0;
      i_ctrl        = '0;
      i_ctrl_tvalid = 1'b0;
      i_resp_tready = 1'b1;
      i_pps         = 1'b0;
      i_rx          = $urandom;
      test_m        = '0;
      run_m         = '0;
      rb_sel_m      = radio_pkg::RB_TEST;
      atr_m         = '{default: '0};
      in_data       = 1'b0;
      bp_en         = 1'b0;
      seq           = '0;
      repeat (5) @(posedge radio_clk);
      #2;
      i_arst_n = 1'b1;
      step(2);

      // Idle state out of reset
      check_value("o_ctrl_tready", o_ctrl_tready, 64'd1, 64'd1);
      check_value("o_resp_tvalid", o_resp_tvalid, 64'd0, 64'd0);
      check_value("o_fe_atr", o_fe_atr, 64'd0, 64'd0);

      send_cmd(radio_pkg::SR_TEST, $urandom);
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));

      // Immediate load, read back a few cycles later
      t_load = {32'h0000_0123, $urandom};
      send_cmd(radio_pkg::SR_TIME, t_load[63:32]);
      send_cmd(radio_pkg::SR_TIME + 8'd1, t_load[31:0]);
      send_cmd(radio_pkg::SR_TIME + 8'd2, 32'd1);
      win_lo = t_load + 64'd1;
      win_hi = t_load + 64'd39;
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME));
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));

      // PPS load; the second pulse captures a time counted from t_load
      t_load = {32'h0000_0777, $urandom};
      send_cmd(radio_pkg::SR_TIME, t_load[63:32]);
      send_cmd(radio_pkg::SR_TIME + 8'd1, t_load[31:0]);
      send_cmd(radio_pkg::SR_TIME + 8'd2, 32'd2);
      wait_idle();
      repeat (2) begin
         i_pps = 1'b1;
         step(3);
         i_pps = 1'b0;
         step(6);
      end
      win_lo = t_load - 64'd1;
      win_hi = t_load + 64'd9;   // Pulses are 9 cycles apart
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_LASTPPS));
      wait_idle();
      pps_val = last_rb;
      win_lo  = t_load + 64'd1;
      win_hi  = t_load + 64'd120;
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TIME));
      wait_idle();
      check_value("vita_time_lastpps", pps_val, t_load - 64'd1, last_rb);
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));

      for (int i = 0; i < 4; i++) begin
         send_cmd(radio_pkg::SR_ATR + 8'(i), $urandom);
      end
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_IO));
      for (int r = 0; r < 4; r++) begin
         send_cmd(radio_pkg::SR_RUN, 32'(r));
         send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_IO));
         wait_idle();
         check_value("o_fe_atr", o_fe_atr, atr_m[r], atr_m[r]);
      end

      send_bad(1);
      send_bad(3);
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));   // Test reg untouched
      wait_idle();

      bp_en = 1'b1;
      repeat (40) begin
         if ($urandom % 2) begin
            send_cmd(radio_pkg::SR_TEST, $urandom);
         end else begin
            send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));
         end
      end
      wait_idle();
      bp_en = 1'b0;
      step(10);

      if (i_dut.radio_ctrl_proc.proc_asserts.fail_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: verif/radio_ctrl_asserts.sv
/*
 * Stream and settings-bus protocol properties for the command processor.
 * fail_cnt counts assertion failures over the whole run.
 * A command is pending from its last beat until the last response beat.
 */
`timescale 1ns/100ps

module radio_ctrl_asserts (
   input logic                radio_clk,
   input logic                i_arst_n,
   input radio_pkg::stream_t  i_ctrl,
   input logic                i_ctrl_tvalid,
   input logic                i_ctrl_tready,
   input radio_pkg::stream_t  i_resp,
   input logic                i_resp_tvalid,
   input logic                i_resp_tready,
   input radio_pkg::set_bus_t i_set
);

   int   fail_cnt = 0;
   logic pend_q;      // Command taken, response not yet finished

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pend_q <= 1'b0;
      end else if (i_resp_tvalid && i_resp_tready && i_resp.tlast) begin
         pend_q <= 1'b0;
      end else if (i_ctrl_tvalid && i_ctrl_tready && i_ctrl.tlast) begin
         pend_q <= 1'b1;
      end
   end

   // Stalled response beat holds valid and data
   resp_hold_a: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      i_resp_tvalid && !i_resp_tready |=> i_resp_tvalid && $stable(i_resp))
      else begin
         fail_cnt++;
         $error("Response valid or data changed while stalled");
      end

   stb_pulse_a: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      i_set.stb |=> !i_set.stb)
      else begin
         fail_cnt++;
         $error("Settings strobe longer than one cycle");
      end

   // No intake while a response is pending
   intake_hold_a: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      pend_q |-> !i_ctrl_tready)
      else begin
         fail_cnt++;
         $error("Command ready high during a response");
      end

endmodule

// File: verif/tb_clkgen.sv
/* Free-running testbench clock, starts low, period set by the parent */
`timescale 1ns/100ps

module tb_clkgen #(
   parameter int PERIOD_NS = 20
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: src/radio_ctrl_top.sv
/*
 * Radio control top level. Everything runs on radio_clk; no clock
 * crossing and no DSP chains here. The command processor drives the
 * settings bus to the timekeeper, settings and ATR blocks.
 */
`timescale 1ns/100ps

module radio_ctrl_top (
   input  logic               radio_clk,
   input  logic               i_arst_n,
   input  radio_pkg::stream_t i_ctrl,
   input  logic               i_ctrl_tvalid,
   output logic               o_ctrl_tready,
   output radio_pkg::stream_t o_resp,
   output logic               o_resp_tvalid,
   input  logic               i_resp_tready,
   input  logic               i_pps,
   input  logic [31:0]        i_rx,
   output logic [31:0]        o_fe_atr
);

   radio_pkg::set_bus_t set_bus;
   logic [63:0]         vita_time;
   logic [63:0]         vita_time_lastpps;
   logic [63:0]         rb_data;
   logic                run_rx;
   logic                run_tx;

   ////////////////////////////////////////////////////////////////////////////
   // Command processor
   radio_ctrl_proc radio_ctrl_proc (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_ctrl        (i_ctrl),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_resp        (o_resp),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .i_rb_data     (rb_data),
      .o_set         (set_bus)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus clients
   timekeeper timekeeper (
      .radio_clk           (radio_clk),
      .i_arst_n            (i_arst_n),
      .i_set               (set_bus),
      .i_pps               (i_pps),
      .o_vita_time         (vita_time),
      .o_vita_time_lastpps (vita_time_lastpps)
   );

   radio_settings radio_settings (
      .radio_clk           (radio_clk),
      .i_arst_n            (i_arst_n),
      .i_set               (set_bus),
      .i_vita_time         (vita_time),
      .i_vita_time_lastpps (vita_time_lastpps),
      .i_rx                (i_rx),
      .i_fe_atr            (o_fe_atr),   // Read back for RB_IO
      .o_run_rx            (run_rx),
      .o_run_tx            (run_tx),
      .o_rb_data           (rb_data)
   );

   fe_atr fe_atr (
      .radio_clk (radio_clk),
      .i_arst_n  (i_arst_n),
      .i_set     (set_bus),
      .i_run_rx  (run_rx),
      .i_run_tx  (run_tx),
      .o_fe_atr  (o_fe_atr)
   );

endmodule

// File: src/fe_atr.sv
/*
 * Front-end ATR control. Four 32-bit registers at SR_ATR+0..3, picked
 * by the run state and registered onto the output every cycle.
 * Output is a plain driven bus, no tristate.
 */
`timescale 1ns/100ps

module fe_atr (
   input  logic                radio_clk,
   input  logic                i_arst_n,
   input  radio_pkg::set_bus_t i_set,
   input  logic                i_run_rx,
   input  logic                i_run_tx,
   output logic [31:0]         o_fe_atr
);

   logic [31:0] atr_q [4];     // idle, rx, tx, fdx
   logic [7:0]  atr_offset;
   logic        atr_hit;
   logic [1:0]  atr_sel;

   assign atr_offset = i_set.addr - radio_pkg::SR_ATR;
   assign atr_hit    = i_set.stb && (atr_offset < 8'd4);

   // Run state maps straight onto the register index
   assign atr_sel    = {i_run_tx, i_run_rx};

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 4; i++) begin
            atr_q[i] <= '0;
         end
      end else if (atr_hit) begin
         atr_q[atr_offset[1:0]] <= i_set.data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Output stage
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_fe_atr <= '0;
      end else begin
         o_fe_atr <= atr_q[atr_sel];     // One cycle behind register or run change
      end
   end

endmodule

// File: src/radio_settings.sv
/*
 * Test, run and readback-select registers plus the readback mux.
 * rb data is combinational from current register state, so the
 * command processor sees a readback-select write in the same response.
 */
`timescale 1ns/100ps

module radio_settings (
   input  logic                radio_clk,
   input  logic                i_arst_n,
   input  radio_pkg::set_bus_t i_set,
   input  logic [63:0]         i_vita_time,
   input  logic [63:0]         i_vita_time_lastpps,
   input  logic [31:0]         i_rx,
   input  logic [31:0]         i_fe_atr,
   output logic                o_run_rx,
   output logic                o_run_tx,
   output logic [63:0]         o_rb_data
);

   logic [31:0]        test_q;
   logic [1:0]         run_q;
   radio_pkg::rb_sel_e rb_sel_q;

   ////////////////////////////////////////////////////////////////////////////
   // Settings registers
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         test_q   <= '0;
         run_q    <= '0;
         rb_sel_q <= radio_pkg::RB_TEST;
      end else if (i_set.stb) begin
         case (i_set.addr)
            radio_pkg::SR_TEST: begin
               test_q <= i_set.data;
            end
            radio_pkg::SR_RUN: begin
               run_q <= i_set.data[1:0];
            end
            radio_pkg::SR_READBACK: begin
               rb_sel_q <= radio_pkg::rb_sel_e'(i_set.data[1:0]);
            end
            default: begin
               // Other addresses belong to other clients
            end
         endcase
      end
   end

   assign o_run_rx = run_q[0];
   assign o_run_tx = run_q[1];

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux
   always_comb begin
      case (rb_sel_q)
         radio_pkg::RB_TEST:    o_rb_data = {32'd0, test_q};
         radio_pkg::RB_TIME:    o_rb_data = i_vita_time;
         radio_pkg::RB_LASTPPS: o_rb_data = i_vita_time_lastpps;
         radio_pkg::RB_IO:      o_rb_data = {i_fe_atr, i_rx};   // FE out high, rx low
         default:               o_rb_data = 64'd0;
      endcase
   end

endmodule

// File: src/timekeeper.sv
/*
 * Radio time counter. Staged hi/lo words load either on commit bit 0
 * or on the next PPS rising edge when commit bit 1 arms it.
 * PPS is async; two sync flops plus an edge flop add three cycles.
 */
`timescale 1ns/100ps

module timekeeper (
   input  logic                radio_clk,
   input  logic                i_arst_n,
   input  radio_pkg::set_bus_t i_set,
   input  logic                i_pps,
   output logic [63:0]         o_vita_time,
   output logic [63:0]         o_vita_time_lastpps
);

   logic [31:0] time_hi_q;
   logic [31:0] time_lo_q;
   logic        pps_armed_q;
   logic [2:0]  pps_q;        // [0] meta, [1] sync, [2] delayed
   logic        pps_edge;
   logic        commit;

   assign commit   = i_set.stb && (i_set.addr == radio_pkg::SR_TIME + 8'd2);
   assign pps_edge = pps_q[1] && !pps_q[2];

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         time_hi_q <= '0;
         time_lo_q <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == radio_pkg::SR_TIME) begin
            time_hi_q <= i_set.data;
         end
         if (i_set.addr == radio_pkg::SR_TIME + 8'd1) begin
            time_lo_q <= i_set.data;
         end
      end
   end

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pps_q               <= '0;
         pps_armed_q         <= 1'b0;
         o_vita_time         <= '0;
         o_vita_time_lastpps <= '0;
      end else begin
         pps_q <= {pps_q[1:0], i_pps};

         if (commit && i_set.data[0]) begin
            o_vita_time <= {time_hi_q, time_lo_q};     // Immediate load
         end else if (pps_armed_q && pps_edge) begin
            o_vita_time <= {time_hi_q, time_lo_q};
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end

         // A fresh commit re-arms even if an edge fires now
         if (commit && i_set.data[1]) begin
            pps_armed_q <= 1'b1;
         end else if (pps_edge) begin
            pps_armed_q <= 1'b0;
         end

         if (pps_edge) begin
            o_vita_time_lastpps <= o_vita_time;
         end
      end
   end

endmodule

// File: src/radio_ctrl_proc.sv
/*
 * Command processor. Takes two-beat commands (header, settings word),
 * issues one settings write each and returns a two-beat response.
 * Only one command is in flight; intake stalls until the response is out.
 * Framing errors drain to tlast and answer PKT_ERR with a zero data beat.
 */
`timescale 1ns/100ps

module radio_ctrl_proc (
   input  logic                radio_clk,
   input  logic                i_arst_n,
   input  radio_pkg::stream_t  i_ctrl,
   input  logic                i_ctrl_tvalid,
   output logic                o_ctrl_tready,
   output radio_pkg::stream_t  o_resp,
   output logic                o_resp_tvalid,
   input  logic                i_resp_tready,
   input  logic [63:0]         i_rb_data,
   output radio_pkg::set_bus_t o_set
);

   typedef enum logic [2:0] {
      ST_HDR,
      ST_PAYLOAD,
      ST_DRAIN,
      ST_STROBE,
      ST_CAPTURE,
      ST_RESP_HDR,
      ST_RESP_DATA
   } state_e;

   state_e               state_q;
   logic                 err_q;       // Framing error on current packet
   logic                 set_stb_q;
   radio_pkg::set_word_t set_word_q;
   radio_pkg::ctrl_hdr_t hdr_q;
   logic [63:0]          rb_q;
   radio_pkg::ctrl_hdr_t resp_hdr;
   logic                 ctrl_xfer;
   logic                 resp_xfer;

   assign o_ctrl_tready = (state_q == ST_HDR) || (state_q == ST_PAYLOAD) ||
                          (state_q == ST_DRAIN);
   assign ctrl_xfer     = i_ctrl_tvalid && o_ctrl_tready;

   // Header beat goes out from the capture cycle onwards
   assign o_resp_tvalid = (state_q == ST_CAPTURE) || (state_q == ST_RESP_HDR) ||
                          (state_q == ST_RESP_DATA);
   assign resp_xfer     = o_resp_tvalid && i_resp_tready;

   ////////////////////////////////////////////////////////////////////////////
   // Control FSM
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q   <= ST_HDR;
         err_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         set_stb_q <= 1'b0;
         case (state_q)
            ST_HDR: begin
               if (ctrl_xfer) begin
                  err_q   <= i_ctrl.tlast;                      // One-beat packet
                  state_q <= i_ctrl.tlast ? ST_STROBE : ST_PAYLOAD;
               end
            end
            ST_PAYLOAD: begin
               if (ctrl_xfer) begin
                  if (i_ctrl.tlast) begin
                     set_stb_q <= 1'b1;
                     state_q   <= ST_STROBE;
                  end else begin
                     err_q   <= 1'b1;                           // Too long, drain rest
                     state_q <= ST_DRAIN;
                  end
               end
            end
            ST_DRAIN: begin
               if (ctrl_xfer && i_ctrl.tlast) begin
                  state_q <= ST_STROBE;
               end
            end
            ST_STROBE: state_q <= ST_CAPTURE;                   // Write lands here
            ST_CAPTURE: begin
               state_q <= resp_xfer ? ST_RESP_DATA : ST_RESP_HDR;
            end
            ST_RESP_HDR: begin
               if (resp_xfer) begin
                  state_q <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (resp_xfer) begin
                  state_q <= ST_HDR;
               end
            end
            default: state_q <= ST_HDR;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Payload registers
   always_ff @(posedge radio_clk) begin
      if (state_q == ST_HDR && ctrl_xfer) begin
         hdr_q <= radio_pkg::ctrl_hdr_t'(i_ctrl.tdata);
      end
      if (state_q == ST_PAYLOAD && ctrl_xfer) begin
         set_word_q <= radio_pkg::set_word_t'(i_ctrl.tdata);
      end
      // Readback sampled once, after the write has settled
      if (state_q == ST_CAPTURE) begin
         rb_q <= err_q ? 64'd0 : i_rb_data;
      end
   end

   always_comb begin
      resp_hdr          = hdr_q;
      resp_hdr.pkt_type = err_q ? radio_pkg::PKT_ERR : radio_pkg::PKT_RESP;
      resp_hdr.reserved = '0;
   end

   assign o_resp = (state_q == ST_RESP_DATA) ?
                   radio_pkg::stream_t'{tlast: 1'b1, tdata: rb_q} :
                   radio_pkg::stream_t'{tlast: 1'b0, tdata: resp_hdr};

   assign o_set  = '{stb: set_stb_q, addr: set_word_q.addr, data: set_word_q.data};

endmodule

// File: src/radio_pkg.sv
/*
 * Shared definitions for the radio control core.
 * One fixed settings-bus address map; every client decodes against it.
 * Stream beats are 64 bits wide with tlast carried alongside.
 */
package radio_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus address map
   localparam logic [7:0] SR_TIME     = 8'd8;   // +0 time hi, +1 time lo, +2 commit
   localparam logic [7:0] SR_ATR      = 8'd12;  // +0 idle, +1 rx, +2 tx, +3 fdx
   localparam logic [7:0] SR_RUN      = 8'd16;  // Bit 0 run_rx, bit 1 run_tx
   localparam logic [7:0] SR_TEST     = 8'd21;
   localparam logic [7:0] SR_READBACK = 8'd32;

   ////////////////////////////////////////////////////////////////////////////
   // Packet formats
   typedef enum logic [1:0] {
      PKT_CMD  = 2'd0,
      PKT_RESP = 2'd1,
      PKT_ERR  = 2'd2
   } pkt_type_e;

   // Header beat, echoed back in the response
   typedef struct packed {
      pkt_type_e   pkt_type;
      logic [11:0] seqnum;
      logic [31:0] sid;
      logic [17:0] reserved;
   } ctrl_hdr_t;

   // Payload beat of a command
   typedef struct packed {
      logic [23:0] reserved;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_word_t;

   typedef struct packed {
      logic        stb;   // One cycle per write
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic        tlast;
      logic [63:0] tdata;
   } stream_t;

   // Readback source select
   typedef enum logic [1:0] {
      RB_TEST    = 2'd0,
      RB_TIME    = 2'd1,
      RB_LASTPPS = 2'd2,
      RB_IO      = 2'd3
   } rb_sel_e;

endpackage
